//--- design/rtc_pkg.sv
`default_nettype none

package rtc_pkg;

	//------------------------------
	// Types
	//------------------------------
	typedef logic [3:0]  bcd_digit_t;  // One BCD digit
	typedef logic [7:0]  bcd_byte_t;   // Two BCD digits, tens in upper nibble
	typedef logic [31:0] time_word_t;  // Packed sec/min/hour/dow
	typedef logic [31:0] date_word_t;  // Packed day/month/year/century

	localparam int DIV_BITS_DEFAULT = 15;  // 32768 Hz rtc_clk

	// Time word field LSBs
	localparam int TW_SEC  = 0;
	localparam int TW_TSEC = 4;
	localparam int TW_MIN  = 8;
	localparam int TW_TMIN = 12;
	localparam int TW_HR   = 16;
	localparam int TW_THR  = 20;
	localparam int TW_DOW  = 24;

	// Date word field LSBs
	localparam int DW_DAY   = 0;
	localparam int DW_TDAY  = 4;
	localparam int DW_MON   = 8;
	localparam int DW_TMON  = 12;
	localparam int DW_YEAR  = 16;
	localparam int DW_TYEAR = 20;
	localparam int DW_CENT  = 24;
	localparam int DW_TCENT = 28;

	// Two-digit BCD value divisible by 4
	// Even tens need ones 0/4/8, odd tens need ones 2/6
	function automatic logic bcd_div4(input bcd_digit_t tens, input bcd_digit_t ones);
		if (tens[0])
			return (ones == 4'd2) || (ones == 4'd6);
		return (ones == 4'd0) || (ones == 4'd4) || (ones == 4'd8);
	endfunction

	// Gregorian rule on century*100 + year
	function automatic logic is_leap_year(input bcd_digit_t tcent, input bcd_digit_t cent,
			input bcd_digit_t tyear, input bcd_digit_t year);
		if ((tyear == 4'd0) && (year == 4'd0))
			return bcd_div4(tcent, cent);  // xx00 leap only when century % 4 == 0
		return bcd_div4(tyear, year);
	endfunction

	// Last day of month, BCD
	function automatic bcd_byte_t days_in_month(input logic tmon, input bcd_digit_t mon,
			input logic leap);
		case ({3'b000, tmon, mon})
			8'h02:                      return leap ? 8'h29 : 8'h28;
			8'h04, 8'h06, 8'h09, 8'h11: return 8'h30;
			default:                    return 8'h31;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- design/rtc_load_if.sv
`timescale 1ns/1ps
`default_nettype none

// Load group shared by both counter blocks
interface rtc_load_if
	import rtc_pkg::*;
();

	logic       update;     // Load strobe, level
	time_word_t load_time;  // Time word to load
	date_word_t load_date;  // Date word to load
	logic       hmode;      // 1 = 24 hour, 0 = 12 hour

	// Driven at the top from cfg inputs
	modport src (
		output update,
		output load_time,
		output load_date,
		output hmode
	);

	modport time_dst (
		input update,
		input load_time,
		input hmode
	);

	modport date_dst (
		input update,
		input load_date
	);

endinterface

`default_nettype wire

//--- design/rtc_second_gen.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_second_gen #(
	parameter int DIV_BITS = 15  // 2^DIV_BITS cycles per second
) (
	input  wire logic rtc_clk,
	input  wire logic rst_n,
	input  wire logic update,   // Time/date load, restarts the second
	input  wire logic restart,  // Divider restart strobe
	input  wire logic halt,     // Freeze time base
	output logic      tick_1s   // One cycle per second
);

	//------------------------------
	// Divider and pulse
	//------------------------------
	logic [DIV_BITS-1:0] div_cnt;  // Free running in normal mode

	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			tick_1s <= 1'b0;
		end else if (update || restart) begin
			// Start a fresh second
			div_cnt <= '0;
			tick_1s <= 1'b0;
		end else if (!halt) begin
			div_cnt <= div_cnt + DIV_BITS'(1);
			tick_1s <= &div_cnt;  // Pulse the cycle after all ones
		end else begin
			// Hold count, drop any pending pulse
			tick_1s <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- design/rtc_time_counter.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_time_counter
	import rtc_pkg::*;
(
	input  wire logic    rtc_clk,
	input  wire logic    rst_n,
	rtc_load_if.time_dst load,
	input  wire logic    tick_1s,    // From second generator
	output logic         day_tick,   // Hour wrap, same cycle as tick
	output time_word_t   time_word
);

	bcd_digit_t sec;   // Seconds
	logic [2:0] tsec;  // Ten seconds
	bcd_digit_t min;   // Minutes
	logic [2:0] tmin;  // Ten minutes
	bcd_digit_t hr;    // Hours
	logic [1:0] thr;   // Ten hours
	logic [2:0] dow;   // Day of week, 1..7

	logic sec_wrap;
	logic tsec_wrap;
	logic min_wrap;
	logic tmin_wrap;
	logic hour_last;
	logic hour_wrap;

	//------------------------------
	// Carry chain
	//------------------------------
	assign sec_wrap  = tick_1s & (sec == 4'd9);
	assign tsec_wrap = sec_wrap & (tsec == 3'd5);
	assign min_wrap  = tsec_wrap & (min == 4'd9);
	assign tmin_wrap = min_wrap & (tmin == 3'd5);

	// Last hour, 23 or 11 by mode
	assign hour_last = load.hmode ? ((thr == 2'd2) && (hr == 4'd3))
	                              : ((thr == 2'd1) && (hr == 4'd1));
	assign hour_wrap = tmin_wrap & hour_last;
	assign day_tick  = hour_wrap;  // Date moves on the same edge

	//------------------------------
	// Seconds
	//------------------------------
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			sec  <= '0;
			tsec <= '0;
		end else if (load.update) begin
			sec  <= load.load_time[TW_SEC +: 4];
			tsec <= load.load_time[TW_TSEC +: 3];
		end else if (tick_1s) begin
			sec <= sec_wrap ? 4'd0 : sec + 4'd1;
			if (sec_wrap)
				tsec <= tsec_wrap ? 3'd0 : tsec + 3'd1;  // 59 -> 00
		end
	end

	// Minutes
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			min  <= '0;
			tmin <= '0;
		end else if (load.update) begin
			min  <= load.load_time[TW_MIN +: 4];
			tmin <= load.load_time[TW_TMIN +: 3];
		end else if (tsec_wrap) begin
			min <= min_wrap ? 4'd0 : min + 4'd1;
			if (min_wrap)
				tmin <= tmin_wrap ? 3'd0 : tmin + 3'd1;
		end
	end

	// Hours, wrap point from hmode
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			hr  <= '0;
			thr <= '0;
		end else if (load.update) begin
			hr  <= load.load_time[TW_HR +: 4];
			thr <= load.load_time[TW_THR +: 2];
		end else if (tmin_wrap) begin
			if (hour_wrap) begin
				hr  <= 4'd0;
				thr <= 2'd0;
			end else if (hr == 4'd9) begin
				hr  <= 4'd0;  // x9 -> (x+1)0
				thr <= thr + 2'd1;
			end else begin
				hr <= hr + 4'd1;
			end
		end
	end

	// Day of week, 7 -> 1
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n)
			dow <= 3'd1;
		else if (load.update)
			dow <= load.load_time[TW_DOW +: 3];
		else if (hour_wrap)
			dow <= (dow == 3'd7) ? 3'd1 : dow + 3'd1;
	end

	//------------------------------
	// Output packing
	//------------------------------
	always_comb begin
		time_word = '0;  // Unused bits read zero
		time_word[TW_SEC +: 4]  = sec;
		time_word[TW_TSEC +: 3] = tsec;
		time_word[TW_MIN +: 4]  = min;
		time_word[TW_TMIN +: 3] = tmin;
		time_word[TW_HR +: 4]   = hr;
		time_word[TW_THR +: 2]  = thr;
		time_word[TW_DOW +: 3]  = dow;
	end

endmodule

`default_nettype wire

//--- design/rtc_date_counter.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_date_counter
	import rtc_pkg::*;
(
	input  wire logic    rtc_clk,
	input  wire logic    rst_n,
	rtc_load_if.date_dst load,
	input  wire logic    day_tick,   // Hour wrap from time counter
	output date_word_t   date_word
);

	bcd_digit_t day;    // Day of month
	logic [1:0] tday;   // Ten days
	bcd_digit_t mon;    // Month
	logic       tmon;   // Ten months
	bcd_digit_t year;   // Year
	bcd_digit_t tyear;  // Ten years
	bcd_digit_t cent;   // Century
	bcd_digit_t tcent;  // Ten centuries

	logic      leap;      // Current year is leap
	bcd_byte_t last_day;  // Last day of current month
	logic      day_wrap;
	logic      mon_wrap;
	logic      year_wrap;
	logic      tyear_wrap;
	logic      cent_wrap;

	//------------------------------
	// Month end detect
	//------------------------------
	assign leap     = is_leap_year(tcent, cent, tyear, year);
	assign last_day = days_in_month(tmon, mon, leap);

	// Carry chain up to ten centuries
	assign day_wrap   = day_tick & ({2'b00, tday, day} == last_day);
	assign mon_wrap   = day_wrap & tmon & (mon == 4'd2);  // Dec -> Jan
	assign year_wrap  = mon_wrap & (year == 4'd9);
	assign tyear_wrap = year_wrap & (tyear == 4'd9);
	assign cent_wrap  = tyear_wrap & (cent == 4'd9);

	//------------------------------
	// Day of month
	//------------------------------
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			day  <= 4'd1;
			tday <= 2'd0;
		end else if (load.update) begin
			day  <= load.load_date[DW_DAY +: 4];
			tday <= load.load_date[DW_TDAY +: 2];
		end else if (day_tick) begin
			if (day_wrap) begin
				day  <= 4'd1;  // Back to 01
				tday <= 2'd0;
			end else if (day == 4'd9) begin
				day  <= 4'd0;
				tday <= tday + 2'd1;
			end else begin
				day <= day + 4'd1;
			end
		end
	end

	// Month, 12 -> 01
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			mon  <= 4'd1;
			tmon <= 1'b0;
		end else if (load.update) begin
			mon  <= load.load_date[DW_MON +: 4];
			tmon <= load.load_date[DW_TMON];
		end else if (day_wrap) begin
			if (mon_wrap) begin
				mon  <= 4'd1;
				tmon <= 1'b0;
			end else if (mon == 4'd9) begin
				mon  <= 4'd0;  // Sep -> Oct
				tmon <= 1'b1;
			end else begin
				mon <= mon + 4'd1;
			end
		end
	end

	// Year, 99 -> 00
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			year  <= '0;
			tyear <= '0;
		end else if (load.update) begin
			year  <= load.load_date[DW_YEAR +: 4];
			tyear <= load.load_date[DW_TYEAR +: 4];
		end else if (mon_wrap) begin
			year <= year_wrap ? 4'd0 : year + 4'd1;
			if (year_wrap)
				tyear <= tyear_wrap ? 4'd0 : tyear + 4'd1;
		end
	end

	// Century, 99 -> 00
	always_ff @(posedge rtc_clk or negedge rst_n) begin
		if (!rst_n) begin
			cent  <= '0;
			tcent <= '0;
		end else if (load.update) begin
			cent  <= load.load_date[DW_CENT +: 4];
			tcent <= load.load_date[DW_TCENT +: 4];
		end else if (tyear_wrap) begin
			cent <= cent_wrap ? 4'd0 : cent + 4'd1;
			if (cent_wrap)
				tcent <= (tcent == 4'd9) ? 4'd0 : tcent + 4'd1;
		end
	end

	//------------------------------
	// Output packing
	//------------------------------
	always_comb begin
		date_word = '0;
		date_word[DW_DAY +: 4]   = day;
		date_word[DW_TDAY +: 2]  = tday;
		date_word[DW_MON +: 4]   = mon;
		date_word[DW_TMON]       = tmon;
		date_word[DW_YEAR +: 4]  = year;
		date_word[DW_TYEAR +: 4] = tyear;
		date_word[DW_CENT +: 4]  = cent;
		date_word[DW_TCENT +: 4] = tcent;
	end

endmodule

`default_nettype wire

//--- design/rtc_top.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_top
	import rtc_pkg::*;
#(
	parameter int DIV_BITS = DIV_BITS_DEFAULT  // Small values speed up simulation
) (
	input  wire logic       rtc_clk,
	input  wire logic       rst_n,
	input  wire logic       cfg_rtc_update,  // Load time and date
	input  wire logic       cfg_rtc_halt,    // Freeze time base
	input  wire logic       cfg_rtc_reset,   // Restart divider
	input  wire logic       cfg_hmode,       // 1 = 24 hour
	input  wire time_word_t cfg_time,
	input  wire date_word_t cfg_date,
	output time_word_t      time_word,
	output date_word_t      date_word
);

	logic tick_1s;   // One second pulse
	logic day_tick;  // Hour wrap carry into date

	//------------------------------
	// Load group
	//------------------------------
	rtc_load_if u_load ();

	assign u_load.update    = cfg_rtc_update;
	assign u_load.load_time = cfg_time;
	assign u_load.load_date = cfg_date;
	assign u_load.hmode     = cfg_hmode;

	//------------------------------
	// Time base and counters
	//------------------------------
	rtc_second_gen #(
		.DIV_BITS (DIV_BITS)
	) u_second_gen (
		.rtc_clk (rtc_clk),
		.rst_n   (rst_n),
		.update  (u_load.update),
		.restart (cfg_rtc_reset),
		.halt    (cfg_rtc_halt),
		.tick_1s (tick_1s)
	);

	rtc_time_counter u_time_counter (
		.rtc_clk   (rtc_clk),
		.rst_n     (rst_n),
		.load      (u_load.time_dst),
		.tick_1s   (tick_1s),
		.day_tick  (day_tick),
		.time_word (time_word)
	);

	rtc_date_counter u_date_counter (
		.rtc_clk   (rtc_clk),
		.rst_n     (rst_n),
		.load      (u_load.date_dst),
		.day_tick  (day_tick),
		.date_word (date_word)
	);

endmodule

`default_nettype wire

//--- testbench/rtc_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_assertions
	import rtc_pkg::*;
(
	input wire logic       rtc_clk,
	input wire logic       rst_n,
	input wire logic       cfg_rtc_update,
	input wire logic       cfg_rtc_halt,
	input wire logic       tick_1s,
	input wire time_word_t cfg_time,
	input wire time_word_t time_word
);

	//------------------------------
	// Time base
	//------------------------------
	a_tick_single: assert property (@(posedge rtc_clk) disable iff (!rst_n)
		tick_1s |=> !tick_1s)
		else $error("tick_1s high two cycles in a row");

	// Pulse is registered, so blocked one cycle later
	a_tick_blocked: assert property (@(posedge rtc_clk) disable iff (!rst_n)
		(cfg_rtc_halt || cfg_rtc_update) |=> !tick_1s)
		else $error("tick_1s during halt or update");

	//------------------------------
	// Time digits
	//------------------------------
	a_sec_digit: assert property (@(posedge rtc_clk) disable iff (!rst_n)
		(time_word[3:0] <= 4'd9) && (time_word[6:4] <= 3'd5))
		else $error("Seconds digit out of range");

	a_load: assert property (@(posedge rtc_clk) disable iff (!rst_n)
		cfg_rtc_update |=> (time_word == $past(cfg_time)))
		else $error("Loaded time word not seen");

endmodule

bind rtc_top rtc_assertions u_assertions (.*);

`default_nettype wire

//--- testbench/tb_rtc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rtc
	import rtc_pkg::*;
();

	localparam int DIV_BITS   = 4;
	localparam int SEC_CYCLES = 1 << DIV_BITS;  // 16 cycles per second

	logic       rtc_clk;
	logic       rst_n;
	logic       cfg_rtc_update;
	logic       cfg_rtc_halt;
	logic       cfg_rtc_reset;
	logic       cfg_hmode;
	time_word_t cfg_time;
	date_word_t cfg_date;
	time_word_t time_word;
	date_word_t date_word;

	logic [31:0] rng;  // xorshift state
	string       cur_test;
	int          time_errs, date_errs, count_errs, wait_errs;

	// Model state, plain integers
	int m_div, m_sec, m_min, m_hour, m_dow, m_day, m_mon, m_year, m_cent;
	logic m_tick;

	rtc_top #(
		.DIV_BITS (DIV_BITS)
	) u_dut (
		.rtc_clk        (rtc_clk),
		.rst_n          (rst_n),
		.cfg_rtc_update (cfg_rtc_update),
		.cfg_rtc_halt   (cfg_rtc_halt),
		.cfg_rtc_reset  (cfg_rtc_reset),
		.cfg_hmode      (cfg_hmode),
		.cfg_time       (cfg_time),
		.cfg_date       (cfg_date),
		.time_word      (time_word),
		.date_word      (date_word)
	);

	initial begin
		rtc_clk = 1'b0;
		forever #5 rtc_clk = ~rtc_clk;
	end

	//------------------------------
	// Helpers
	//------------------------------
	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic int rand_below(input int n);
		return int'(next_rand() % 32'(n));
	endfunction

	function automatic logic leap_year(input int full);
		return ((full % 4 == 0) && (full % 100 != 0)) || (full % 400 == 0);
	endfunction

	function automatic int month_days(input int mon, input int full);
		case (mon)
			2:            return leap_year(full) ? 29 : 28;
			4, 6, 9, 11:  return 30;
			default:      return 31;
		endcase
	endfunction

	function automatic int bcd2(input logic [3:0] tens, input logic [3:0] ones);
		return int'(tens) * 10 + int'(ones);
	endfunction

	function automatic time_word_t make_time(input int h, input int m, input int s, input int dow);
		return {5'd0, 3'(dow), 2'd0, 2'(h / 10), 4'(h % 10), 1'b0, 3'(m / 10), 4'(m % 10),
			1'b0, 3'(s / 10), 4'(s % 10)};
	endfunction

	function automatic date_word_t make_date(input int c, input int y, input int mo, input int d);
		return {4'(c / 10), 4'(c % 10), 4'(y / 10), 4'(y % 10), 3'd0, 1'(mo / 10), 4'(mo % 10),
			2'd0, 2'(d / 10), 4'(d % 10)};
	endfunction

	// Legal random time for the hour mode
	function automatic time_word_t rand_time(input logic mode, input logic near_end);
		int h, m, s;
		h = near_end ? (mode ? 23 : 11) : rand_below(mode ? 24 : 12);
		m = near_end ? 59 : rand_below(60);
		s = near_end ? 50 + rand_below(10) : rand_below(60);
		return make_time(h, m, s, 1 + rand_below(7));
	endfunction

	// Legal random date, month end half of the time
	function automatic date_word_t rand_date();
		int c, y, mo, d;
		c  = rand_below(100);
		y  = rand_below(100);
		mo = 1 + rand_below(12);
		d  = ((next_rand() & 32'h1) != 0) ? month_days(mo, c * 100 + y) : 1 + rand_below(28);
		return make_date(c, y, mo, d);
	endfunction

	//------------------------------
	// Reference model
	//------------------------------
	task automatic model_reset();
		m_div = 0;
		m_tick = 1'b0;
		m_sec = 0;
		m_min = 0;
		m_hour = 0;
		m_dow = 1;
		m_day = 1;
		m_mon = 1;
		m_year = 0;
		m_cent = 0;
	endtask

	task automatic model_next_day();
		if (m_day == month_days(m_mon, m_cent * 100 + m_year)) begin
			m_day = 1;
			m_mon = m_mon + 1;
			if (m_mon == 13) begin
				m_mon = 1;
				m_year = (m_year + 1) % 100;
				if (m_year == 0)
					m_cent = (m_cent + 1) % 100;
			end
		end else begin
			m_day = m_day + 1;
		end
	endtask

	task automatic model_next_second(input logic mode);
		m_sec = m_sec + 1;
		if (m_sec < 60)
			return;
		m_sec = 0;
		m_min = m_min + 1;
		if (m_min < 60)
			return;
		m_min = 0;
		m_hour = m_hour + 1;
		if (m_hour == (mode ? 24 : 12)) begin  // Hour wrap moves day
			m_hour = 0;
			m_dow = (m_dow == 7) ? 1 : m_dow + 1;
			model_next_day();
		end
	endtask

	// Inputs read here hold pre-edge values
	always @(posedge rtc_clk) begin
		if (!rst_n) begin
			model_reset();
		end else begin
			if (cfg_rtc_update) begin
				m_sec  = bcd2({1'b0, cfg_time[6:4]}, cfg_time[3:0]);
				m_min  = bcd2({1'b0, cfg_time[14:12]}, cfg_time[11:8]);
				m_hour = bcd2({2'b0, cfg_time[21:20]}, cfg_time[19:16]);
				m_dow  = int'(cfg_time[26:24]);
				m_day  = bcd2({2'b0, cfg_date[5:4]}, cfg_date[3:0]);
				m_mon  = bcd2({3'b0, cfg_date[12]}, cfg_date[11:8]);
				m_year = bcd2(cfg_date[23:20], cfg_date[19:16]);
				m_cent = bcd2(cfg_date[31:28], cfg_date[27:24]);
			end else if (m_tick) begin
				model_next_second(cfg_hmode);
			end
			// Divider after the counters, they used the old pulse
			if (cfg_rtc_update || cfg_rtc_reset) begin
				m_div = 0;
				m_tick = 1'b0;
			end else if (!cfg_rtc_halt) begin
				m_tick = (m_div == SEC_CYCLES - 1);
				m_div = (m_div + 1) % SEC_CYCLES;
			end else begin
				m_tick = 1'b0;
			end
		end
	end

	//------------------------------
	// Compare tasks
	//------------------------------
	task automatic check_time(input string name, input time_word_t exp, input time_word_t act);
		if (exp !== act) begin
			time_errs++;
			$display("Error %s: time expected %08h, actual %08h", name, exp, act);
		end
	endtask

	task automatic check_date(input string name, input date_word_t exp, input date_word_t act);
		if (exp !== act) begin
			date_errs++;
			$display("Error %s: date expected %08h, actual %08h", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			count_errs++;
			$display("Error %s: cycles expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// Every cycle against the model, outputs settled at the falling edge
	always @(negedge rtc_clk) begin
		if (rst_n) begin
			check_time(cur_test, make_time(m_hour, m_min, m_sec, m_dow), time_word);
			check_date(cur_test, make_date(m_cent, m_year, m_mon, m_day), date_word);
		end
	end

	//------------------------------
	// Stimulus tasks
	//------------------------------
	task automatic load_words(input time_word_t t, input date_word_t d, input logic mode);
		@(posedge rtc_clk);
		cfg_time       <= t;
		cfg_date       <= d;
		cfg_hmode      <= mode;
		cfg_rtc_update <= 1'b1;
		@(posedge rtc_clk);
		cfg_rtc_update <= 1'b0;
	endtask

	// Waits for n second pulses, ends on a falling edge
	task automatic wait_ticks(input int n);
		int cnt, cyc;
		cnt = 0;
		cyc = 0;
		while ((cnt < n) && (cyc < n * (SEC_CYCLES + 2) + 20)) begin
			@(negedge rtc_clk);
			cyc++;
			if (m_tick)
				cnt++;
		end
		if (cnt < n) begin
			wait_errs++;
			$display("%s: second pulses stopped before %0d arrived", cur_test, n);
		end
	endtask

	// Called on the falling edge after the restarting edge
	task automatic wait_time_change(output int cycles);
		time_word_t prev;
		prev = time_word;
		cycles = 0;
		while (cycles < 4 * SEC_CYCLES) begin
			@(posedge rtc_clk);
			cycles++;
			@(negedge rtc_clk);
			if (time_word !== prev)
				return;
		end
		wait_errs++;
		$display("%s: time word never changed after the restart", cur_test);
	endtask

	task automatic month_end(input int c, input int y, input int mo, input int d,
			input date_word_t exp);
		load_words(make_time(23, 59, 59, 1), make_date(c, y, mo, d), 1'b1);
		wait_ticks(1);
		@(negedge rtc_clk);
		check_date("month end", exp, date_word);
	endtask

	//------------------------------
	// Test sequence
	//------------------------------
	initial begin
		int cyc, n, i;
		logic mode;
		rng = 32'hce8a;
		rst_n = 1'b0;
		cfg_rtc_update = 1'b0;
		cfg_rtc_halt = 1'b0;
		cfg_rtc_reset = 1'b0;
		cfg_hmode = 1'b1;
		cfg_time = '0;
		cfg_date = '0;
		time_errs = 0;
		date_errs = 0;
		count_errs = 0;
		wait_errs = 0;
		model_reset();

		cur_test = "reset";
		repeat (8) @(posedge rtc_clk);
		rst_n <= 1'b1;
		@(negedge rtc_clk);
		check_time("reset", make_time(0, 0, 0, 1), time_word);
		check_date("reset", make_date(0, 0, 1, 1), date_word);
		wait_time_change(cyc);
		check_count("reset first tick", SEC_CYCLES + 1, cyc);

		cur_test = "count";
		repeat (6) begin
			mode = (next_rand() & 32'h1) != 0;
			load_words(rand_time(mode, 1'b0), rand_date(), mode);
			wait_ticks(1 + rand_below(200));
		end
		// Digit carries that random loads rarely reach
		load_words(make_time(0, 9, 58, 1), rand_date(), 1'b1);
		wait_ticks(4);
		load_words(make_time(9, 59, 58, 2), rand_date(), 1'b0);
		wait_ticks(4);
		load_words(make_time(19, 59, 58, 5), rand_date(), 1'b1);
		wait_ticks(4);

		cur_test = "hour wrap";
		for (i = 0; i < 6; i++) begin
			mode = (i < 3);
			load_words(rand_time(mode, 1'b1) | (i == 0 ? 32'h0700_0000 : 32'h0), rand_date(),
				mode);
			wait_ticks(12);
		end

		cur_test = "month end";
		month_end(19, 0, 2, 28, make_date(19, 0, 3, 1));  // 1900 not leap
		month_end(20, 0, 2, 28, make_date(20, 0, 2, 29));
		month_end(20, 0, 2, 29, make_date(20, 0, 3, 1));
		month_end(20, 24, 2, 28, make_date(20, 24, 2, 29));
		month_end(20, 23, 2, 28, make_date(20, 23, 3, 1));
		month_end(20, 24, 4, 30, make_date(20, 24, 5, 1));
		month_end(20, 24, 1, 31, make_date(20, 24, 2, 1));
		month_end(99, 99, 12, 31, make_date(0, 0, 1, 1));
		repeat (8) begin
			load_words(make_time(23, 59, 58, 3), rand_date(), 1'b1);
			wait_ticks(4);
		end

		cur_test = "halt";
		repeat (4) begin
			@(posedge rtc_clk);
			cfg_rtc_halt <= 1'b1;
			repeat (5 + rand_below(40)) @(posedge rtc_clk);
			cfg_rtc_halt <= 1'b0;
			wait_ticks(2);
		end

		cur_test = "restart";
		repeat (3) begin
			repeat (rand_below(SEC_CYCLES)) @(posedge rtc_clk);
			@(posedge rtc_clk);
			cfg_rtc_reset <= 1'b1;
			@(posedge rtc_clk);
			cfg_rtc_reset <= 1'b0;
			@(negedge rtc_clk);
			wait_time_change(cyc);
			check_count("restart delay", SEC_CYCLES + 1, cyc);
		end

		cur_test = "mixed";
		for (i = 0; i < 3000; i++) begin
			n = rand_below(100);
			mode = (next_rand() & 32'h1) != 0;
			@(posedge rtc_clk);
			cfg_rtc_update <= 1'b0;
			cfg_rtc_reset  <= 1'b0;
			if (n < 2) begin
				cfg_time       <= rand_time(mode, (next_rand() & 32'h1) != 0);
				cfg_date       <= rand_date();
				cfg_hmode      <= mode;  // Mode changes only with a load
				cfg_rtc_update <= 1'b1;
			end else if (n < 4) begin
				cfg_rtc_reset <= 1'b1;
			end else if (n < 6) begin
				cfg_rtc_halt <= ~cfg_rtc_halt;
			end
		end
		@(posedge rtc_clk);
		cfg_rtc_update <= 1'b0;
		cfg_rtc_reset  <= 1'b0;
		cfg_rtc_halt   <= 1'b0;
		wait_ticks(2);

		$display("Errors: time %0d, date %0d, count %0d, wait %0d", time_errs, date_errs,
			count_errs, wait_errs);
		if (time_errs + date_errs + count_errs + wait_errs == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// Hang guard
	initial begin
		#2000000;
		$display("Simulation ran past its time limit");
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
design/rtc_pkg.sv
design/rtc_load_if.sv
design/rtc_second_gen.sv
design/rtc_time_counter.sv
design/rtc_date_counter.sv
design/rtc_top.sv
testbench/rtc_assertions.sv
testbench/tb_rtc.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then scan the log for the fail message

rm -f sim.log

verilator --binary --timing --assert --top-module tb_rtc -f flist.f \
	-Mdir obj_dir -o sim_rtc \
	&& ./obj_dir/sim_rtc > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log

grep -q "Some tests failed" sim.log && exit 1 || exit 0
